// File: source/qpu_exu_params.svh
// Execution stage parameters
`ifndef QPU_EXU_PARAMS_SVH
`define QPU_EXU_PARAMS_SVH

// Classical data path
`define QPU_XLEN             32
`define QPU_RF_NUM           16  // Register 0 reads zero
`define QPU_RFIDX_WIDTH      4

// Timing and event outputs
`define QPU_TIME_WIDTH       16
`define QPU_EVENT_NUM        4   // One valid bit per channel
`define QPU_EVENT_WIRE_WIDTH 12

// Entries in each of the time and event queues
`define QPU_QUEUE_DEPTH      4

`endif

// File: source/qpu_isa_pkg.sv
// Instruction set types
`include "qpu_exu_params.svh"

package qpu_isa_pkg;

  // Codes outside this list decode as NOP
  typedef enum logic [3:0] {
    NOP   = 4'd0,
    ADD   = 4'd1,  // rd = rs1 + rs2
    ADDI  = 4'd2,  // rd = rs1 + imm
    TIME  = 4'd3,  // Time point rs1 + imm
    EVENT = 4'd4   // Event mask and data from imm
  } opcode_t;

  typedef logic [`QPU_XLEN-1:0] xlen_t;

  typedef logic [`QPU_RFIDX_WIDTH-1:0] rf_idx_t;

  // Zero-extended when used as an operand
  typedef logic [15:0] imm_t;

endpackage

// File: source/qpu_timing_pkg.sv
// Timing output types
`include "qpu_exu_params.svh"

package qpu_timing_pkg;

  typedef logic [`QPU_TIME_WIDTH-1:0] qtime_t;

  typedef logic [`QPU_EVENT_NUM-1:0] event_mask_t;

  typedef logic [`QPU_EVENT_WIRE_WIDTH-1:0] event_data_t;

  // Mask in the upper bits, data in the lower bits
  typedef logic [`QPU_EVENT_NUM+`QPU_EVENT_WIRE_WIDTH-1:0] event_entry_t;

endpackage

// File: source/qpu_exu_decode.sv
// Instruction field decoder
module qpu_exu_decode
  import qpu_isa_pkg::*;
(
  input  xlen_t   i_instr,
  output opcode_t o_opcode,
  output rf_idx_t o_rd,
  output rf_idx_t o_rs1,
  output rf_idx_t o_rs2,
  output imm_t    o_imm
);

  logic [3:0] op_bits;

  // Field layout, top down
  assign op_bits = i_instr[31:28];
  assign o_rd    = i_instr[27:24];
  assign o_rs1   = i_instr[23:20];
  assign o_rs2   = i_instr[19:16];
  assign o_imm   = i_instr[15:0];

  // Only legal operations leave the decoder
  always_comb begin
    case (op_bits)
      4'd1: begin
        o_opcode = ADD;
      end
      4'd2: begin
        o_opcode = ADDI;
      end
      4'd3: begin
        o_opcode = TIME;
      end
      4'd4: begin
        o_opcode = EVENT;
      end
      default: begin
        o_opcode = NOP;  // Includes code 0
      end
    endcase
  end

endmodule

// File: source/qpu_exu_regfile.sv
// Classical register file
`include "qpu_exu_params.svh"

module qpu_exu_regfile
  import qpu_isa_pkg::*;
(
  input  logic    clk,
  input  logic    i_arst_n,
  input  rf_idx_t i_rs1,
  input  rf_idx_t i_rs2,
  output xlen_t   o_rs1_data,
  output xlen_t   o_rs2_data,
  input  logic    i_wen,
  input  rf_idx_t i_rd,
  input  xlen_t   i_wdata
);

  xlen_t rf_q [1:`QPU_RF_NUM-1];  // No storage behind register 0

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < `QPU_RF_NUM; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wen && (i_rd != '0)) begin
      rf_q[i_rd] <= i_wdata;
    end
  end

  // Two asynchronous read ports
  assign o_rs1_data = (i_rs1 == '0) ? '0 : rf_q[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : rf_q[i_rs2];

endmodule

// File: source/qpu_exu_alu.sv
// Execution ALU and stage handshake
`include "qpu_exu_params.svh"

module qpu_exu_alu
  import qpu_isa_pkg::*, qpu_timing_pkg::*;
(
  input  logic         i_valid,
  output logic         o_ready,
  input  opcode_t      i_opcode,
  input  rf_idx_t      i_rd,
  input  imm_t         i_imm,
  input  xlen_t        i_rs1_data,
  input  xlen_t        i_rs2_data,
  input  logic         i_tiq_full,
  input  logic         i_evq_full,
  output logic         o_rf_wen,
  output rf_idx_t      o_rf_rd,
  output xlen_t        o_rf_wdata,
  output logic         o_tiq_push,
  output qtime_t       o_tiq_time,
  output logic         o_evq_push,
  output event_entry_t o_evq_entry
);

  logic take;

  // Stall only when the target queue is full
  assign o_ready = ~(((i_opcode == TIME) & i_tiq_full) | ((i_opcode == EVENT) & i_evq_full));
  assign take    = i_valid & o_ready;

  // Write back
  assign o_rf_wen   = take & ((i_opcode == ADD) | (i_opcode == ADDI));
  assign o_rf_rd    = i_rd;
  assign o_rf_wdata = (i_opcode == ADD) ? (i_rs1_data + i_rs2_data)
                                        : (i_rs1_data + xlen_t'(i_imm));

  // Queue pushes
  assign o_tiq_push  = take & (i_opcode == TIME);
  assign o_tiq_time  = i_rs1_data[`QPU_TIME_WIDTH-1:0] + qtime_t'(i_imm);
  assign o_evq_push  = take & (i_opcode == EVENT);
  assign o_evq_entry = {event_mask_t'(i_imm[`QPU_EVENT_WIRE_WIDTH +: `QPU_EVENT_NUM]),
                        event_data_t'(i_imm[`QPU_EVENT_WIRE_WIDTH-1:0])};

endmodule

// File: source/qpu_exu_fifo.sv
// Circular buffer FIFO
`include "qpu_exu_params.svh"

module qpu_exu_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = `QPU_QUEUE_DEPTH
) (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output T     o_data,
  output logic o_full,
  output logic o_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = i_push & ~o_full;
  assign do_pop  = i_pop & ~o_empty;
  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_empty = (count == '0);
  assign o_data  = mem[rd_ptr];  // Head visible without a pop

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      if (do_push != do_pop) count <= do_push ? count + 1'b1 : count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= i_data;
  end

endmodule

// File: source/qpu_exu_timing_queue.sv
// Time and event queues with trigger firing
`include "qpu_exu_params.svh"

module qpu_exu_timing_queue
  import qpu_timing_pkg::*;
(
  input  logic         clk,
  input  logic         i_arst_n,
  input  logic         i_tiq_push,
  input  qtime_t       i_tiq_time,
  input  logic         i_evq_push,
  input  event_entry_t i_evq_entry,
  output logic         o_tiq_full,
  output logic         o_evq_full,
  output logic         o_busy,
  input  logic         i_trigger,
  input  qtime_t       i_trigger_clk,
  output logic         o_trigger_clk_ena,
  output event_mask_t  o_trigger_valid,
  output event_data_t  o_trigger_data
);

  qtime_t       tiq_head;
  event_entry_t evq_head;
  logic         tiq_empty;
  logic         evq_empty;
  logic         fire;
  logic         tiq_pop;
  logic         evq_pop;

  //////////////////////////////////////////////////
  // Queues
  qpu_exu_fifo #(.T(qtime_t), .DEPTH(`QPU_QUEUE_DEPTH)) u_tiq (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (i_tiq_push),
    .i_data   (i_tiq_time),
    .i_pop    (tiq_pop),
    .o_data   (tiq_head),
    .o_full   (o_tiq_full),
    .o_empty  (tiq_empty)
  );

  qpu_exu_fifo #(.T(event_entry_t), .DEPTH(`QPU_QUEUE_DEPTH)) u_evq (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (i_evq_push),
    .i_data   (i_evq_entry),
    .i_pop    (evq_pop),
    .o_data   (evq_head),
    .o_full   (o_evq_full),
    .o_empty  (evq_empty)
  );

  //////////////////////////////////////////////////
  // Fire on a head time match
  assign fire    = o_trigger_clk_ena & ~tiq_empty & ~evq_empty & (tiq_head == i_trigger_clk);
  assign tiq_pop = fire;
  assign evq_pop = fire;  // Heads leave as a pair
  assign o_busy  = ~tiq_empty | ~evq_empty;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_trigger_clk_ena <= 1'b0;
      o_trigger_valid   <= '0;
    end else begin
      if (i_trigger) o_trigger_clk_ena <= 1'b1;  // Sticky until reset
      o_trigger_valid <= fire ? evq_head[`QPU_EVENT_WIRE_WIDTH +: `QPU_EVENT_NUM] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) o_trigger_data <= evq_head[`QPU_EVENT_WIRE_WIDTH-1:0];
  end

endmodule

// File: source/qpu_exu.sv
// Quantum control execution stage
module qpu_exu
  import qpu_isa_pkg::*, qpu_timing_pkg::*;
(
  input  logic        clk,
  input  logic        i_arst_n,
  input  logic        i_valid,
  output logic        o_ready,
  input  xlen_t       i_instr,
  input  logic        i_trigger,
  input  qtime_t      i_trigger_clk,
  output logic        o_trigger_clk_ena,
  output event_mask_t o_trigger_valid,
  output event_data_t o_trigger_data,
  output logic        o_exu_active
);

  opcode_t      dec_opcode;
  rf_idx_t      dec_rd;
  rf_idx_t      dec_rs1;
  rf_idx_t      dec_rs2;
  imm_t         dec_imm;
  xlen_t        rf_rs1_data;
  xlen_t        rf_rs2_data;
  logic         rf_wen;
  rf_idx_t      rf_rd;
  xlen_t        rf_wdata;
  logic         tiq_push;
  qtime_t       tiq_time;
  logic         tiq_full;
  logic         evq_push;
  event_entry_t evq_entry;
  logic         evq_full;
  logic         tq_busy;

  //////////////////////////////////////////////////
  // Decode
  qpu_exu_decode u_decode (
    .i_instr  (i_instr),
    .o_opcode (dec_opcode),
    .o_rd     (dec_rd),
    .o_rs1    (dec_rs1),
    .o_rs2    (dec_rs2),
    .o_imm    (dec_imm)
  );

  //////////////////////////////////////////////////
  // Execute
  qpu_exu_alu u_alu (
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .i_opcode    (dec_opcode),
    .i_rd        (dec_rd),
    .i_imm       (dec_imm),
    .i_rs1_data  (rf_rs1_data),
    .i_rs2_data  (rf_rs2_data),
    .i_tiq_full  (tiq_full),
    .i_evq_full  (evq_full),
    .o_rf_wen    (rf_wen),
    .o_rf_rd     (rf_rd),
    .o_rf_wdata  (rf_wdata),
    .o_tiq_push  (tiq_push),
    .o_tiq_time  (tiq_time),
    .o_evq_push  (evq_push),
    .o_evq_entry (evq_entry)
  );

  //////////////////////////////////////////////////
  // Result
  qpu_exu_regfile u_regfile (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_rs1      (dec_rs1),
    .i_rs2      (dec_rs2),
    .o_rs1_data (rf_rs1_data),
    .o_rs2_data (rf_rs2_data),
    .i_wen      (rf_wen),
    .i_rd       (rf_rd),
    .i_wdata    (rf_wdata)
  );

  qpu_exu_timing_queue u_timing_queue (
    .clk               (clk),
    .i_arst_n          (i_arst_n),
    .i_tiq_push        (tiq_push),
    .i_tiq_time        (tiq_time),
    .i_evq_push        (evq_push),
    .i_evq_entry       (evq_entry),
    .o_tiq_full        (tiq_full),
    .o_evq_full        (evq_full),
    .o_busy            (tq_busy),
    .i_trigger         (i_trigger),
    .i_trigger_clk     (i_trigger_clk),
    .o_trigger_clk_ena (o_trigger_clk_ena),
    .o_trigger_valid   (o_trigger_valid),
    .o_trigger_data    (o_trigger_data)
  );

  assign o_exu_active = tq_busy | i_valid;  // Pending events or a waiting instruction

endmodule

// File: testbench/qpu_exu_asserts.sv
// Timing queue assertions
module qpu_exu_asserts
  import qpu_timing_pkg::*;
(
  input logic        clk,
  input logic        i_arst_n,
  input logic        i_tiq_pop,
  input logic        i_evq_pop,
  input logic        i_tiq_empty,
  input logic        i_evq_empty,
  input logic        i_clk_ena,
  input event_mask_t i_trigger_valid
);

  int fail_count = 0;

  // Pops only ever target a filled queue
  assert property (@(posedge clk) disable iff (!i_arst_n)
    !(i_tiq_pop && i_tiq_empty) && !(i_evq_pop && i_evq_empty))
    else begin
      fail_count++;
      $error("Pop from an empty queue");
    end

  assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_trigger_valid != '0) |-> i_clk_ena)
    else begin
      fail_count++;
      $error("Trigger valid while the trigger clock is disabled");
    end

  assert property (@(posedge clk) disable iff (!i_arst_n) i_tiq_pop == i_evq_pop)
    else begin
      fail_count++;
      $error("Time and event queues popped apart");
    end

endmodule

bind qpu_exu_timing_queue qpu_exu_asserts u_asserts (
  .clk             (clk),
  .i_arst_n        (i_arst_n),
  .i_tiq_pop       (tiq_pop),
  .i_evq_pop       (evq_pop),
  .i_tiq_empty     (tiq_empty),
  .i_evq_empty     (evq_empty),
  .i_clk_ena       (o_trigger_clk_ena),
  .i_trigger_valid (o_trigger_valid)
);

// File: testbench/qpu_exu_tb.sv
// Execution stage testbench
module qpu_exu_tb
  import qpu_isa_pkg::*, qpu_timing_pkg::*;
;

  localparam int READY_TIMEOUT = 500;
  localparam int FIRE_TIMEOUT  = 300;
  localparam int IDLE_TIMEOUT  = 20;
  localparam int RUN_LIMIT     = 5000;

  logic        clk;
  logic        i_arst_n;
  logic        i_valid;
  logic        o_ready;
  xlen_t       i_instr;
  logic        i_trigger;
  qtime_t      i_trigger_clk;
  logic        o_trigger_clk_ena;
  event_mask_t o_trigger_valid;
  event_data_t o_trigger_data;
  logic        o_exu_active;

  xlen_t       instrs [$];
  qtime_t      exp_time [$];
  event_mask_t exp_mask [$];
  event_data_t exp_data [$];
  qtime_t      model_time [$];
  imm_t        model_event [$];
  xlen_t       model_rf [16];
  logic [15:0] lfsr;
  logic        run_done;
  int          value_errors;
  int          other_errors;
  int          stall_cycles;
  int          taken_count;

  qpu_exu i_dut (
    .clk               (clk),
    .i_arst_n          (i_arst_n),
    .i_valid           (i_valid),
    .o_ready           (o_ready),
    .i_instr           (i_instr),
    .i_trigger         (i_trigger),
    .i_trigger_clk     (i_trigger_clk),
    .o_trigger_clk_ena (o_trigger_clk_ena),
    .o_trigger_valid   (o_trigger_valid),
    .o_trigger_data    (o_trigger_data),
    .o_exu_active      (o_exu_active)
  );

  always #4 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  task automatic flag_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    value_errors++;
    $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  task automatic note_failure(input string what);
    other_errors++;
    $display("%0t: %s", $time, what);
  endtask

  //////////////////////////////////////////////////
  // Golden file and reference model
  task automatic load_program();
    int          fd;
    string       line;
    xlen_t       word;
    logic [15:0] t;
    logic [3:0]  m;
    logic [11:0] d;
    fd = $fopen("testbench/qpu_exu_golden.txt", "r");
    if (fd == 0) begin
      note_failure("Could not open the golden file");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line[0] == "#") continue;
      if ($sscanf(line, "I %h", word) == 1) begin
        instrs.push_back(word);
        case (word[31:28])  // Register model, r0 stays zero
          4'd1: if (word[27:24] != 0)
            model_rf[word[27:24]] = model_rf[word[23:20]] + model_rf[word[19:16]];
          4'd2: if (word[27:24] != 0)
            model_rf[word[27:24]] = model_rf[word[23:20]] + {16'h0, word[15:0]};
          4'd3: model_time.push_back(model_rf[word[23:20]][15:0] + word[15:0]);
          4'd4: model_event.push_back(word[15:0]);
          default: ;
        endcase
      end else if ($sscanf(line, "E %h %h %h", t, m, d) == 3) begin
        exp_time.push_back(t);
        exp_mask.push_back(m);
        exp_data.push_back(d);
      end
    end
    $fclose(fd);
    assert (model_time.size() == exp_time.size() && model_event.size() == exp_time.size())
      else note_failure("Golden fire count differs from the program");
    foreach (exp_time[k]) begin
      assert (model_time[k] == exp_time[k])
        else flag_mismatch("model time", model_time[k], exp_time[k]);
      assert (model_event[k] == {exp_mask[k], exp_data[k]})
        else flag_mismatch("model event", model_event[k], {exp_mask[k], exp_data[k]});
    end
  endtask

  //////////////////////////////////////////////////
  // Concurrent threads
  task automatic run_trigger_clock();
    int n;
    i_trigger = 1'b1;
    @(negedge clk);
    assert (!o_trigger_clk_ena) else flag_mismatch("early clk_ena", o_trigger_clk_ena, 0);
    @(posedge clk);
    #1;
    i_trigger = 1'b0;
    @(negedge clk);
    assert (o_trigger_clk_ena) else flag_mismatch("clk_ena after trigger", o_trigger_clk_ena, 1);
    for (n = 0; n < RUN_LIMIT && !run_done; n++) begin
      @(posedge clk);
      #1;
      if (o_trigger_clk_ena) i_trigger_clk = i_trigger_clk + 1'b1;
    end
  endtask

  task automatic feed_program();
    logic [1:0] gap;
    logic       taken;
    int         w;
    foreach (instrs[k]) begin
      i_valid = 1'b1;
      i_instr = instrs[k];
      taken   = 1'b0;
      for (w = 0; w < READY_TIMEOUT && !taken; w++) begin
        @(negedge clk);  // Ready is settled until the next edge
        if (o_ready) taken = 1'b1;
        else stall_cycles++;
        @(posedge clk);
        #1;
      end
      if (!taken) begin
        note_failure($sformatf("Instruction %0d was never taken", k));
        break;
      end
      taken_count++;
      lfsr   = lfsr_next(lfsr);
      gap[0] = lfsr[0];
      lfsr   = lfsr_next(lfsr);
      gap[1] = lfsr[0];
      i_valid = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
    i_valid = 1'b0;
  endtask

  task automatic check_fires();
    qtime_t prev_clk;  // Trigger clock at the last edge
    logic   found;
    int     cyc;
    prev_clk = i_trigger_clk;
    foreach (exp_time[k]) begin
      found = 1'b0;
      for (cyc = 0; cyc < FIRE_TIMEOUT && !found; cyc++) begin
        @(negedge clk);
        if (o_trigger_valid != '0) found = 1'b1;
        else prev_clk = i_trigger_clk;
      end
      if (!found) begin
        note_failure($sformatf("No fire seen for event %0d", k));
        break;
      end
      assert (prev_clk == exp_time[k]) else flag_mismatch("fire time", prev_clk, exp_time[k]);
      assert (o_trigger_valid == exp_mask[k])
        else flag_mismatch("trigger valid", o_trigger_valid, exp_mask[k]);
      assert (o_trigger_data == exp_data[k])
        else flag_mismatch("trigger data", o_trigger_data, exp_data[k]);
      @(negedge clk);
      assert (o_trigger_valid == '0) else flag_mismatch("valid after fire", o_trigger_valid, 0);
      prev_clk = i_trigger_clk;
    end
    run_done = 1'b1;
  endtask

  initial begin
    logic idle;
    int   cyc;
    int   assert_errors;
    clk           = 1'b0;
    i_arst_n      = 1'b0;
    i_valid       = 1'b0;
    i_instr       = '0;
    i_trigger     = 1'b0;
    i_trigger_clk = '0;
    lfsr          = 16'd58115;
    run_done      = 1'b0;
    value_errors  = 0;
    other_errors  = 0;
    stall_cycles  = 0;
    taken_count   = 0;
    foreach (model_rf[r]) model_rf[r] = '0;
    load_program();
    repeat (10) @(posedge clk);
    #1;
    i_arst_n = 1'b1;

    // Idle state after reset
    @(negedge clk);
    assert (o_ready) else flag_mismatch("o_ready after reset", o_ready, 1);
    assert (!o_trigger_clk_ena) else flag_mismatch("clk_ena after reset", o_trigger_clk_ena, 0);
    assert (o_trigger_valid == '0) else flag_mismatch("valid after reset", o_trigger_valid, 0);
    assert (!o_exu_active) else flag_mismatch("exu_active after reset", o_exu_active, 0);
    @(posedge clk);
    #1;

    fork
      run_trigger_clock();
      feed_program();
      check_fires();
    join

    assert (taken_count == instrs.size())
      else flag_mismatch("taken count", taken_count, instrs.size());
    assert (stall_cycles > 0) else flag_mismatch("stall cycles", stall_cycles, 1);
    idle = 1'b0;
    for (cyc = 0; cyc < IDLE_TIMEOUT && !idle; cyc++) begin
      @(negedge clk);
      idle = !o_exu_active;
    end
    assert (idle) else note_failure("o_exu_active stayed high after the last fire");

    assert_errors = i_dut.u_timing_queue.u_asserts.fail_count;
    $display("Value errors: %0d, other errors: %0d, assertion errors: %0d",
             value_errors, other_errors, assert_errors);
    if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: testbench/qpu_exu_golden.txt
# I <instr hex>  opcode rd rs1 rs2 imm16, fed in order
# E <time hex> <mask hex> <data hex>  expected fires in firing order
I 21000040  # r1 = 0x40
I 22100020  # r2 = r1 + 0x20
I 13120000  # r3 = r1 + r2
I 20000005  # Write to r0 is dropped
I 30000050  # Time r0 + 0x50
I 400010ab
I f1000123  # Unknown opcode leaves r1 alone
I 30100030  # Time r1 + 0x30
I 40002123
I 30300000  # Time r3
I 4000cfff
I 14320000  # r4 = r3 + r2
I 30400010
I 40008001
I 25000190  # r5 = 0x190
I 40001101  # Events queued ahead of their times
I 40002202
I 40004404
I 40008808
I 30500000  # Five time points, the fifth stalls
I 3050000a
I 30500014
I 3050001e
I 30500028
I 4000f5a5
E 0050 1 0ab
E 0070 2 123
E 00a0 c fff
E 0110 8 001
E 0190 1 101
E 019a 2 202
E 01a4 4 404
E 01ae 8 808
E 01b8 f 5a5

// File: flist.f
+incdir+source
source/qpu_isa_pkg.sv
source/qpu_timing_pkg.sv
source/qpu_exu_decode.sv
source/qpu_exu_regfile.sv
source/qpu_exu_alu.sv
source/qpu_exu_fifo.sv
source/qpu_exu_timing_queue.sv
source/qpu_exu.sv
testbench/qpu_exu_asserts.sv
testbench/qpu_exu_tb.sv
